/* fmisc_top.f */
+incdir+hdl
hdl/float_types_pkg.sv
hdl/fmisc_ops_pkg.sv
hdl/fmisc_request_port.sv
hdl/float_classifier.sv
hdl/float_miscellaneous.sv
hdl/fmisc_result_port.sv
hdl/fmisc_top.sv
tests/fmisc_clock_gen.sv
tests/fmisc_tb.sv

/* tests/fmisc_tb.sv */
`timescale 1ns/1ps

/* Testbench for the float miscellaneous unit
   Four-phase producer and consumer, reference model and protocol monitor */

`include "fmisc_macros.svh"

module fmisc_tb;

    localparam int WAIT_LIMIT = 200;
    localparam int IDLE_LIMIT = 2000;

    logic                       clk_i;
    logic                       rst_i;
    logic                       in_req_i;
    fmisc_ops_pkg::fmisc_req_t  in_data_i;
    logic                       in_ack_o;
    logic                       out_req_o;
    fmisc_ops_pkg::fmisc_resp_t out_data_o;
    logic                       out_ack_i;

    fmisc_ops_pkg::fmisc_resp_t expected_q[$];
    fmisc_ops_pkg::fmisc_req_t  stream[40];
    logic [31:0]                lfsr_state;
    logic [`TAG_WIDTH-1:0]      next_tag;
    logic                       random_ack;
    int                         check_count;
    int                         error_count;
    int                         protocol_checks;
    int                         protocol_errors;
    int                         test_count;

    fmisc_clock_gen clock_gen_inst (
        .clk_o (clk_i),
        .rst_o (rst_i)
    );

    fmisc_top fmisc_top_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .in_req_i   (in_req_i),
        .in_data_i  (in_data_i),
        .in_ack_o   (in_ack_o),
        .out_req_o  (out_req_o),
        .out_data_o (out_data_o),
        .out_ack_i  (out_ack_i)
    );

    // ----------------------------------------
    // Reference model and helpers
    // ----------------------------------------

    // Built straight from the FCLASS, sign injection and move rules
    function automatic fmisc_ops_pkg::fmisc_resp_t expected_response(
        input fmisc_ops_pkg::fmisc_req_t req
    );
        fmisc_ops_pkg::fmisc_resp_t resp;
        logic [7:0]                 exp_field;
        logic [22:0]                sig_field;
        logic                       sgn;
        float_types_pkg::fclass_t   code;
        exp_field = req.operand.exponent;
        sig_field = req.operand.significand;
        sgn       = req.operand.sign;
        if (exp_field == 8'hff && sig_field != 0)
            code = sig_field[22] ? float_types_pkg::Q_NAN : float_types_pkg::S_NAN;
        else if (exp_field == 8'hff)
            code = sgn ? float_types_pkg::N_INFINITY : float_types_pkg::P_INFINITY;
        else if (exp_field == 8'h00 && sig_field == 0)
            code = sgn ? float_types_pkg::N_ZERO : float_types_pkg::P_ZERO;
        else if (exp_field == 8'h00)
            code = sgn ? float_types_pkg::N_SUBNORMAL : float_types_pkg::P_SUBNORMAL;
        else
            code = sgn ? float_types_pkg::N_NORMAL : float_types_pkg::P_NORMAL;
        resp.result      = req.operand;
        resp.to_int_file = 1'b0;
        resp.tag         = req.tag;
        case (req.op)
            fmisc_ops_pkg::FCLASS: begin
                resp.result      = {28'd0, code};
                resp.to_int_file = 1'b1;
            end
            fmisc_ops_pkg::FSGNJ:   resp.result[31] = req.sign_src;
            fmisc_ops_pkg::FSGNJN:  resp.result[31] = ~req.sign_src;
            fmisc_ops_pkg::FSGNJX:  resp.result[31] = req.sign_src ^ sgn;
            fmisc_ops_pkg::FMV_X_W: resp.to_int_file = 1'b1;
            default:                resp.to_int_file = 1'b0;
        endcase
        return resp;
    endfunction

    function automatic fmisc_ops_pkg::fmisc_req_t make_req(
        input fmisc_ops_pkg::fmisc_uop_t op,
        input logic [31:0]               word,
        input logic                      sign_src
    );
        fmisc_ops_pkg::fmisc_req_t req;
        req.op       = op;
        req.operand  = word;
        req.sign_src = sign_src;
        req.tag      = '0;
        return req;
    endfunction

    // Right-shift Galois LFSR with the taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    task automatic draw_bits(input int count, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("CHECK FAILED time %0t ns: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic protocol_error(input string what);
        protocol_errors++;
        error_count++;
        $display("Protocol error at time %0t ns: %s", $time, what);
    endtask

    task automatic protocol_mismatch(input string name, input logic [63:0] expected,
                                     input logic [63:0] actual);
        protocol_errors++;
        error_count++;
        $display("CHECK FAILED time %0t ns: %s expected 0x%0h, actual 0x%0h",
                 $time, name, expected, actual);
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout at time %0t ns: %s", $time, what);
        $display("Regression failed");
        $finish;
    endtask

    task automatic report_test(input string name, input int requests, input int errors_before);
        test_count++;
        $display("Test %s: %0d requests, %0d errors", name, requests,
                 error_count - errors_before);
    endtask

    // ----------------------------------------
    // Producer
    // ----------------------------------------

    // Each drive follows a rising edge, so the DUT sees it one edge later
    task automatic send_request(input fmisc_ops_pkg::fmisc_req_t req);
        int cycles;
        req.tag  = next_tag;
        next_tag = next_tag + 1'b1;
        expected_q.push_back(expected_response(req));
        cycles = 0;
        @(posedge clk_i);
        while (in_ack_o !== 1'b0) begin
            if (cycles == WAIT_LIMIT)
                abort_on_timeout("in_ack_o stayed high before a new request");
            cycles++;
            @(posedge clk_i);
        end
        in_req_i  <= 1'b1;
        in_data_i <= req;
        cycles = 0;
        @(posedge clk_i);
        while (in_ack_o !== 1'b1) begin
            if (cycles == WAIT_LIMIT)
                abort_on_timeout("in_ack_o never answered a raised in_req_i");
            cycles++;
            @(posedge clk_i);
        end
        in_req_i <= 1'b0;
    endtask

    // All outstanding responses consumed and both handshakes closed
    task automatic drain_responses();
        int cycles;
        cycles = 0;
        @(posedge clk_i);
        while (expected_q.size() != 0 || out_req_o !== 1'b0 || out_ack_i !== 1'b0) begin
            if (cycles == IDLE_LIMIT)
                abort_on_timeout("responses still missing after the last request");
            cycles++;
            @(posedge clk_i);
        end
    endtask

    // ----------------------------------------
    // Consumer
    // ----------------------------------------

    task automatic wait_out_req(input logic level, input int limit);
        int cycles;
        cycles = 0;
        @(posedge clk_i);
        while (out_req_o !== level) begin
            if (cycles == limit)
                abort_on_timeout("out_req_o did not reach the expected level");
            cycles++;
            @(posedge clk_i);
        end
    endtask

    initial begin : consumer
        logic [31:0]                delay;
        fmisc_ops_pkg::fmisc_resp_t expected;
        forever begin
            wait_out_req(1'b1, IDLE_LIMIT);
            // Compare while out_req_o holds the data stable
            if (expected_q.size() == 0) begin
                protocol_error("a response arrived with no request outstanding");
            end else begin
                expected = expected_q.pop_front();
                check_value("out_data_o.tag", expected.tag, out_data_o.tag);
                check_value("out_data_o.result", expected.result, out_data_o.result);
                check_value("out_data_o.to_int_file", expected.to_int_file,
                            out_data_o.to_int_file);
            end
            delay = '0;
            if (random_ack)
                draw_bits(3, delay);
            repeat (delay) @(posedge clk_i);
            out_ack_i <= 1'b1;
            wait_out_req(1'b0, WAIT_LIMIT);
            out_ack_i <= 1'b0;
        end
    end : consumer

    // ----------------------------------------
    // Protocol monitor
    // ----------------------------------------

    logic                       in_req_q;
    logic                       in_ack_q;
    logic                       out_req_q;
    fmisc_ops_pkg::fmisc_resp_t out_data_q;
    logic                       ack_released;
    logic                       ack_high_seen;

    always @(posedge clk_i) begin
        if (rst_i) begin
            in_req_q      <= 1'b0;
            in_ack_q      <= 1'b0;
            out_req_q     <= 1'b0;
            out_data_q    <= '0;
            ack_released  <= 1'b1;
            ack_high_seen <= 1'b0;
        end else begin
            // A rising ack must answer a request seen on the previous edge
            protocol_checks++;
            assert (in_ack_q || !in_ack_o || in_req_q)
                else protocol_error("in_ack_o rose while in_req_i was low");
            if (out_req_o && out_req_q) begin
                protocol_checks++;
                assert (out_data_o === out_data_q)
                    else protocol_mismatch("out_data_o", out_data_q, out_data_o);
            end
            // The next request may only start after the last ack went high and then low
            if (out_req_o && !out_req_q) begin
                protocol_checks++;
                assert (ack_released)
                    else protocol_error("out_req_o rose again before out_ack_i was seen low");
                ack_released <= 1'b0;
            end else if (out_ack_i) begin
                ack_high_seen <= 1'b1;
            end else if (ack_high_seen) begin
                ack_released  <= 1'b1;
                ack_high_seen <= 1'b0;
            end
            in_req_q   <= in_req_i;
            in_ack_q   <= in_ack_o;
            out_req_q  <= out_req_o;
            out_data_q <= out_data_o;
        end
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin : main
        logic [31:0]                class_ops[12];
        logic [31:0]                move_ops[3];
        logic [31:0]                bits;
        logic [31:0]                word;
        logic [2:0]                 op_code;
        fmisc_ops_pkg::fmisc_uop_t  op;
        int                         errors_before;
        int                         cycles;
        int                         i;
        int                         j;
        in_req_i        = 1'b0;
        in_data_i       = '0;
        out_ack_i       = 1'b0;
        lfsr_state      = 32'hed8d74a1;
        next_tag        = '0;
        random_ack      = 1'b0;
        check_count     = 0;
        error_count     = 0;
        protocol_checks = 0;
        protocol_errors = 0;
        test_count      = 0;
        // Infinities, normals, subnormals, zeros, then signaling and quiet NaNs of each sign
        class_ops = '{32'hff800000, 32'hbf800000, 32'h80000001, 32'h80000000,
                      32'h00000000, 32'h00400000, 32'h3f800000, 32'h7f800000,
                      32'h7f800001, 32'h7fc00000, 32'hff800001, 32'hffc00000};
        move_ops  = '{32'h12345678, 32'hdeadbeef, 32'h7fc00001};

        cycles = 0;
        @(posedge clk_i);
        while (rst_i !== 1'b0) begin
            if (cycles == WAIT_LIMIT)
                abort_on_timeout("reset was never released");
            cycles++;
            @(posedge clk_i);
        end
        protocol_checks += 2;
        assert (in_ack_o === 1'b0) else protocol_mismatch("in_ack_o", 1'b0, in_ack_o);
        assert (out_req_o === 1'b0) else protocol_mismatch("out_req_o", 1'b0, out_req_o);

        errors_before = error_count;
        for (i = 0; i < 12; i++)
            send_request(make_req(fmisc_ops_pkg::FCLASS, class_ops[i], 1'b0));
        drain_responses();
        report_test("classification", 12, errors_before);

        errors_before = error_count;
        for (i = 0; i < 3; i++) begin
            op = fmisc_ops_pkg::fmisc_uop_t'(i + 1);
            for (j = 0; j < 4; j++)
                send_request(make_req(op, {j[1], 31'h40490fdb}, j[0]));
        end
        drain_responses();
        report_test("sign injection", 12, errors_before);

        errors_before = error_count;
        for (i = 0; i < 3; i++) begin
            send_request(make_req(fmisc_ops_pkg::FMV_X_W, move_ops[i], 1'b0));
            send_request(make_req(fmisc_ops_pkg::FMV_W_X, move_ops[i], 1'b1));
        end
        drain_responses();
        report_test("register moves", 6, errors_before);

        // The stream is drawn up front so the consumer alone steps the LFSR for its delays
        for (i = 0; i < 40; i++) begin
            draw_bits(3, bits);
            op_code = bits % 6;
            draw_bits(32, word);
            draw_bits(2, bits);
            if (bits[1:0] == 2'd0)
                word[30:23] = 8'hff;
            else if (bits[1:0] == 2'd1)
                word[30:23] = 8'h00;
            draw_bits(1, bits);
            stream[i] = make_req(fmisc_ops_pkg::fmisc_uop_t'(op_code), word, bits[0]);
        end
        errors_before = error_count;
        random_ack    = 1'b1;
        for (i = 0; i < 40; i++)
            send_request(stream[i]);
        drain_responses();
        report_test("back-pressure", 40, errors_before);

        test_count++;
        $display("Test protocol: %0d checks, %0d errors", protocol_checks, protocol_errors);
        $display("Summary: %0d tests, %0d checks, %0d errors", test_count,
                 check_count + protocol_checks, error_count);
        if (error_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end : main

endmodule : fmisc_tb

/* tests/fmisc_clock_gen.sv */
`timescale 1ns/1ps

/* Testbench clock and reset source
   Free running clock with a synchronous reset held for the first cycles */

module fmisc_clock_gen #(
    parameter int HALF_PERIOD_NS = 20,
    parameter int RESET_CYCLES   = 4
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    // Reset drops on a rising edge like any other driven input
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule : fmisc_clock_gen

/* hdl/fmisc_top.sv */
`timescale 1ns/1ps

/* Float miscellaneous unit
   Request port, classifier, operation logic and result port in a row */

module fmisc_top (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       in_req_i,
    input  fmisc_ops_pkg::fmisc_req_t  in_data_i,
    output logic                       in_ack_o,
    output logic                       out_req_o,
    output fmisc_ops_pkg::fmisc_resp_t out_data_o,
    input  logic                       out_ack_i
);

    // Request port to classifier
    logic                         req_valid;
    fmisc_ops_pkg::fmisc_req_t    req_data;
    logic                         cls_accept;

    // Classifier to result port, through the operation logic
    logic                         stg_valid;
    fmisc_ops_pkg::fmisc_staged_t stg_data;
    fmisc_ops_pkg::fmisc_resp_t   comb_resp;
    logic                         res_accept;

    fmisc_request_port request_port_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .in_req_i    (in_req_i),
        .in_data_i   (in_data_i),
        .in_ack_o    (in_ack_o),
        .req_valid_o (req_valid),
        .req_data_o  (req_data),
        .accept_i    (cls_accept)
    );

    float_classifier classifier_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .valid_i  (req_valid),
        .data_i   (req_data),
        .accept_o (cls_accept),
        .valid_o  (stg_valid),
        .data_o   (stg_data),
        .accept_i (res_accept)
    );

    // Pure logic, the response is ready in the same cycle as the staged item
    float_miscellaneous miscellaneous_inst (
        .stage_i (stg_data),
        .resp_o  (comb_resp)
    );

    fmisc_result_port result_port_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .valid_i    (stg_valid),
        .data_i     (comb_resp),
        .accept_o   (res_accept),
        .out_req_o  (out_req_o),
        .out_data_o (out_data_o),
        .out_ack_i  (out_ack_i)
    );

endmodule : fmisc_top

/* hdl/fmisc_result_port.sv */
`timescale 1ns/1ps

/* Result port of the float miscellaneous unit
   Holds one response and offers it on a four-phase sender */

module fmisc_result_port (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic                       valid_i,
    input  fmisc_ops_pkg::fmisc_resp_t data_i,
    output logic                       accept_o,
    output logic                       out_req_o,
    output fmisc_ops_pkg::fmisc_resp_t out_data_o,
    input  logic                       out_ack_i
);

    // Sender handshake phases
    // TX_DROP keeps req high for the cycle after ack is first seen
    typedef enum logic [1:0] {
        TX_EMPTY,
        TX_WAIT_ACK,
        TX_DROP,
        TX_WAIT_LOW
    } tx_state_t;

    tx_state_t                  state_q;
    fmisc_ops_pkg::fmisc_resp_t data_q;
    logic                       load;

    // ----------------------------------------
    // Handshake
    // ----------------------------------------

    // The register is free only once the whole four-phase cycle has closed
    assign accept_o = (state_q == TX_EMPTY);
    assign load     = valid_i && accept_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= TX_EMPTY;
        end else begin
            case (state_q)
                TX_EMPTY:
                    if (load)
                        state_q <= TX_WAIT_ACK;
                TX_WAIT_ACK:
                    if (out_ack_i)
                        state_q <= TX_DROP;
                TX_DROP:
                    state_q <= TX_WAIT_LOW;
                // A new request may not start before the consumer releases ack
                TX_WAIT_LOW:
                    if (!out_ack_i)
                        state_q <= TX_EMPTY;
                default:
                    state_q <= TX_EMPTY;
            endcase
        end
    end

    assign out_req_o = (state_q == TX_WAIT_ACK) || (state_q == TX_DROP);

    // ----------------------------------------
    // Response register
    // ----------------------------------------

    // Loaded only when empty, so the data stays fixed while req is high
    always_ff @(posedge clk_i) begin
        if (load)
            data_q <= data_i;
    end

    assign out_data_o = data_q;

endmodule : fmisc_result_port

/* hdl/float_miscellaneous.sv */
`timescale 1ns/1ps

/* Miscellaneous float operations
   Classify, sign injection and register file moves, all combinational */

`include "fmisc_macros.svh"

module float_miscellaneous (
    input  fmisc_ops_pkg::fmisc_staged_t stage_i,
    output fmisc_ops_pkg::fmisc_resp_t   resp_o
);

    float_types_pkg::float_t       operand;
    float_types_pkg::float_flags_t flags;
    float_types_pkg::fclass_t      class_code;
    float_types_pkg::float_t       injected;

    assign operand = stage_i.req.operand;
    assign flags   = stage_i.flags;

    // ----------------------------------------
    // Classify
    // ----------------------------------------

    // NaN ignores the sign and uses the top significand bit to tell quiet from signaling
    // The flags are one-hot, so the order of the other tests does not matter
    always_comb begin : class_encode
        if (flags.is_nan)
            class_code = operand.significand[`SIG_WIDTH-1] ? float_types_pkg::Q_NAN
                                                           : float_types_pkg::S_NAN;
        else if (flags.is_infinity)
            class_code = operand.sign ? float_types_pkg::N_INFINITY
                                      : float_types_pkg::P_INFINITY;
        else if (flags.is_zero)
            class_code = operand.sign ? float_types_pkg::N_ZERO
                                      : float_types_pkg::P_ZERO;
        else if (flags.is_subnormal)
            class_code = operand.sign ? float_types_pkg::N_SUBNORMAL
                                      : float_types_pkg::P_SUBNORMAL;
        else
            class_code = operand.sign ? float_types_pkg::N_NORMAL
                                      : float_types_pkg::P_NORMAL;
    end : class_encode

    // ----------------------------------------
    // Sign injection and result select
    // ----------------------------------------

    // Exponent and significand always pass through, only the sign is replaced
    always_comb begin : sign_inject
        injected = operand;
        case (stage_i.req.op)
            fmisc_ops_pkg::FSGNJN:
                injected.sign = !stage_i.req.sign_src;
            fmisc_ops_pkg::FSGNJX:
                injected.sign = stage_i.req.sign_src ^ operand.sign;
            default:
                injected.sign = stage_i.req.sign_src;
        endcase
    end : sign_inject

    always_comb begin : result_select
        case (stage_i.req.op)
            // Class code lands in the low bits of an integer result
            fmisc_ops_pkg::FCLASS:
                resp_o.result = {{(`FLOAT_WIDTH-`CLASS_WIDTH){1'b0}}, class_code};
            fmisc_ops_pkg::FSGNJ,
            fmisc_ops_pkg::FSGNJN,
            fmisc_ops_pkg::FSGNJX:
                resp_o.result = injected;
            // Moves keep the raw bits, the destination flag does the work
            default:
                resp_o.result = operand;
        endcase
    end : result_select

    // FCLASS and FMV_X_W write an integer register, the rest write a float register
    assign resp_o.to_int_file = (stage_i.req.op == fmisc_ops_pkg::FCLASS)
                             || (stage_i.req.op == fmisc_ops_pkg::FMV_X_W);

    assign resp_o.tag = stage_i.req.tag;

endmodule : float_miscellaneous

/* hdl/float_classifier.sv */
`timescale 1ns/1ps

/* Operand classifier stage
   Decodes the kind of the operand and registers it with the request */

module float_classifier (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         valid_i,
    input  fmisc_ops_pkg::fmisc_req_t    data_i,
    output logic                         accept_o,
    output logic                         valid_o,
    output fmisc_ops_pkg::fmisc_staged_t data_o,
    input  logic                         accept_i
);

    logic                          exp_ones;
    logic                          exp_zero;
    logic                          sig_zero;
    float_types_pkg::float_flags_t flags;
    logic                          valid_q;
    fmisc_ops_pkg::fmisc_staged_t  data_q;

    // ----------------------------------------
    // Flag decode
    // ----------------------------------------

    // Field tests on the incoming operand
    assign exp_ones = &data_i.operand.exponent;
    assign exp_zero = ~|data_i.operand.exponent;
    assign sig_zero = ~|data_i.operand.significand;

    // The two exponent extremes split four ways on the significand
    // Any other exponent is a normal number
    always_comb begin : flag_decode
        flags.is_infinity  = exp_ones && sig_zero;
        flags.is_nan       = exp_ones && !sig_zero;
        flags.is_zero      = exp_zero && sig_zero;
        flags.is_subnormal = exp_zero && !sig_zero;
        flags.is_normal    = !exp_ones && !exp_zero;
    end : flag_decode

    // ----------------------------------------
    // Stage register
    // ----------------------------------------

    // Room for a new item when empty or when the current one leaves this cycle
    assign accept_o = !valid_q || accept_i;

    always_ff @(posedge clk_i) begin
        if (rst_i)
            valid_q <= 1'b0;
        else if (accept_o)
            valid_q <= valid_i;
    end

    // Request and flags are kept together so later stages see a matched pair
    always_ff @(posedge clk_i) begin
        if (valid_i && accept_o) begin
            data_q.req   <= data_i;
            data_q.flags <= flags;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule : float_classifier

/* hdl/fmisc_request_port.sv */
`timescale 1ns/1ps

/* Request port of the float miscellaneous unit
   Four-phase receiver that parks one request for the classifier */

module fmisc_request_port (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      in_req_i,
    input  fmisc_ops_pkg::fmisc_req_t in_data_i,
    output logic                      in_ack_o,
    output logic                      req_valid_o,
    output fmisc_ops_pkg::fmisc_req_t req_data_o,
    input  logic                      accept_i
);

    // Receiver handshake phases
    // RX_RELEASE keeps ack high for one more cycle after req has gone low
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_ACKED,
        RX_RELEASE
    } rx_state_t;

    rx_state_t                 state_q;
    logic                      full_q;
    fmisc_ops_pkg::fmisc_req_t data_q;
    logic                      capture;

    // ----------------------------------------
    // Handshake
    // ----------------------------------------

    // Ack is low only in RX_IDLE, so this also means ack is currently low
    // A full holding register stalls the producer by withholding ack
    assign capture = in_req_i && (state_q == RX_IDLE) && !full_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= RX_IDLE;
        end else begin
            case (state_q)
                RX_IDLE:
                    if (capture)
                        state_q <= RX_ACKED;
                // Wait for the producer to drop its request
                RX_ACKED:
                    if (!in_req_i)
                        state_q <= RX_RELEASE;
                RX_RELEASE:
                    state_q <= RX_IDLE;
                default:
                    state_q <= RX_IDLE;
            endcase
        end
    end

    assign in_ack_o = (state_q != RX_IDLE);

    // ----------------------------------------
    // Holding register
    // ----------------------------------------

    // Capture needs an empty register and release needs a full one, so they never meet
    always_ff @(posedge clk_i) begin
        if (rst_i)
            full_q <= 1'b0;
        else if (capture)
            full_q <= 1'b1;
        else if (accept_i && full_q)
            full_q <= 1'b0;
    end

    // Data is sampled while the producer holds it stable under req
    always_ff @(posedge clk_i) begin
        if (capture)
            data_q <= in_data_i;
    end

    assign req_valid_o = full_q;
    assign req_data_o  = data_q;

endmodule : fmisc_request_port

/* hdl/fmisc_ops_pkg.sv */
/* Operation types of the float miscellaneous unit
   Operation codes and the payloads that move between its stages */

`include "fmisc_macros.svh"

package fmisc_ops_pkg;

    // ----------------------------------------
    // Operation codes
    // ----------------------------------------

    // FMV_X_W moves float bits to the integer file, FMV_W_X goes the other way
    typedef enum logic [2:0] {
        FCLASS  = 3'd0,
        FSGNJ   = 3'd1,
        FSGNJN  = 3'd2,
        FSGNJX  = 3'd3,
        FMV_X_W = 3'd4,
        FMV_W_X = 3'd5
    } fmisc_uop_t;

    // ----------------------------------------
    // Stage payloads
    // ----------------------------------------

    // Request as it arrives on the input port
    // The sign source is the sign bit of the second operand for sign injection
    typedef struct packed {
        fmisc_uop_t              op;
        float_types_pkg::float_t operand;
        logic                    sign_src;
        logic [`TAG_WIDTH-1:0]   tag;
    } fmisc_req_t;

    // Request after the classifier, carrying the decoded operand kind
    typedef struct packed {
        fmisc_req_t                    req;
        float_types_pkg::float_flags_t flags;
    } fmisc_staged_t;

    // Response on the output port
    // to_int_file selects the integer register file as the destination
    typedef struct packed {
        logic [`FLOAT_WIDTH-1:0] result;
        logic                    to_int_file;
        logic [`TAG_WIDTH-1:0]   tag;
    } fmisc_resp_t;

endpackage : fmisc_ops_pkg

/* hdl/float_types_pkg.sv */
/* Float format types
   Operand layout, class codes and the one-hot class flags */

`include "fmisc_macros.svh"

package float_types_pkg;

    // ----------------------------------------
    // Operand layout
    // ----------------------------------------

    // Sign sits in the top bit, so the struct lines up with the raw 32-bit word
    typedef struct packed {
        logic                  sign;
        logic [`EXP_WIDTH-1:0] exponent;
        logic [`SIG_WIDTH-1:0] significand;
    } float_t;

    // ----------------------------------------
    // Class codes
    // ----------------------------------------

    // Negative classes take the low codes and positive ones mirror them upwards
    // NaN codes ignore the sign bit
    typedef enum logic [`CLASS_WIDTH-1:0] {
        N_INFINITY  = 4'd0,
        N_NORMAL    = 4'd1,
        N_SUBNORMAL = 4'd2,
        N_ZERO      = 4'd3,
        P_ZERO      = 4'd4,
        P_SUBNORMAL = 4'd5,
        P_NORMAL    = 4'd6,
        P_INFINITY  = 4'd7,
        S_NAN       = 4'd8,
        Q_NAN       = 4'd9
    } fclass_t;

    // Operand kind as decoded by the classifier stage
    // Exactly one of these bits is set for any operand
    typedef struct packed {
        logic is_infinity;
        logic is_zero;
        logic is_normal;
        logic is_subnormal;
        logic is_nan;
    } float_flags_t;

endpackage : float_types_pkg

/* hdl/fmisc_macros.svh */
/* Format widths for the float miscellaneous unit
   Single precision layout, class code and request tag sizes */

`ifndef FMISC_MACROS_SVH
`define FMISC_MACROS_SVH

// ----------------------------------------
// Float format
// ----------------------------------------

// Full width of a single-precision operand
`define FLOAT_WIDTH 32

// Biased exponent field
`define EXP_WIDTH 8

// Stored significand field, hidden bit not included
`define SIG_WIDTH 23

// ----------------------------------------
// Unit specific widths
// ----------------------------------------

// FCLASS returns this many low bits, the rest of the result is zero
`define CLASS_WIDTH 4

// Request identifier, carried from request to response untouched
`define TAG_WIDTH 4

`endif
